//--- filelist.f
+incdir+include
logic/axi_wr_pkg.sv
logic/rr_slot_picker.sv
logic/wr_slot_table.sv
logic/aw_issue.sv
logic/w_stream.sv
logic/b_tracker.sv
logic/axi_wr_master.sv
dv/axi_wr_slave_model.sv
dv/tb_axi_wr_master.sv

//--- Bender.yml
package:
  name: axi_wr_master

sources:
  - include_dirs:
      - include
    files:
      - logic/axi_wr_pkg.sv
      - logic/rr_slot_picker.sv
      - logic/wr_slot_table.sv
      - logic/aw_issue.sv
      - logic/w_stream.sv
      - logic/b_tracker.sv
      - logic/axi_wr_master.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - dv/axi_wr_slave_model.sv
      - dv/tb_axi_wr_master.sv

//--- dv/tb_axi_wr_master.sv
`timescale 1ns/1ps
`include "axi_wr_defs.svh"

module tb_axi_wr_master;
  import axi_wr_pkg::*;

  localparam int NUM_SLOTS      = 4;
  localparam int NUM_REQS       = 40;
  localparam int TIMEOUT_CYCLES = NUM_REQS * (MAX_BURST_LEN + 12) * 4;

  logic                clk;
  logic                rst_n;
  logic                user_req_valid;
  logic                user_req_ready;
  aw_req_t             user_req;
  burst_t              user_burst;
  aw_req_t             aw;
  logic                awvalid;
  logic                awready;
  w_beat_t             w;
  logic                wvalid;
  logic                wready;
  logic [ID_W-1:0]     bid;
  logic [RESP_W-1:0]   bresp;
  logic                bvalid;
  logic                bready;

  logic [31:0] lfsr;
  logic [7:0]  rnd;
  int          b_allow;
  aw_req_t     reqs [NUM_REQS];
  burst_t      bursts [NUM_REQS];
  int          cur_idx;
  int          pool [$];
  int          aw_order [$];
  int          beat_k;
  int          aw_count;
  int          w_done;
  int          b_seen;
  int          cycles;
  logic        aw_stall;
  logic        w_stall;
  aw_req_t     aw_prev;
  w_beat_t     w_prev;

  axi_wr_master #(.NUM_SLOTS(NUM_SLOTS)) DUT (.*);

  axi_wr_slave_model u_slave (.*);

  // Fibonacci LFSR with taps 32 22 2 1, stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      r    = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  // Beat k of a burst with last set on beat len
  function automatic w_beat_t expected_beat(input aw_req_t r, input burst_t b, input int k);
    w_beat_t e;
    e.data = b.words[k];
    e.strb = b.strbs[k];
    e.last = (k == int'(r.len));
    return e;
  endfunction

  // Address bits 11:4 hold the request index, so addresses never repeat
  function automatic void build_requests();
    logic [19:0] hi;
    for (int i = 0; i < NUM_REQS; i++) begin
      hi            = rand_bits(20);
      reqs[i].id    = ID_W'(rand_bits(2));
      reqs[i].addr  = {hi, 8'(i), 4'h0};
      reqs[i].len   = LEN_W'(rand_bits(2));
      reqs[i].size  = 3'd2;
      reqs[i].burst = `AXI_BURST_INCR;
      for (int k = 0; k < MAX_BURST_LEN; k++) begin
        bursts[i].words[k] = rand_bits(32);
        bursts[i].strbs[k] = STRB_W'(rand_bits(4));
      end
    end
  endfunction

  task automatic stop_run();
    $display("Something failed");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  task automatic compare_value(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
    if (exp !== act) begin
      $display("** Error %s: expected %0h, actual %0h", name, exp, act);
      stop_run();
    end
  endtask

  // Called on a falling edge and returns on the falling edge after the handshake
  task automatic send_request(input int i);
    cur_idx        = i;
    user_req       = reqs[i];
    user_burst     = bursts[i];
    user_req_valid = 1'b1;
    while (!user_req_ready) begin
      @(negedge clk);
    end
    @(negedge clk);
    user_req_valid = 1'b0;
  endtask

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(negedge clk) begin
    rnd = rand_bits(8);
  end

  // ------------------------------------------------------------------
  // Compare process on every rising edge
  // ------------------------------------------------------------------
  always @(posedge clk) begin
    int hit;
    if (rst_n) begin
      cycles++;
      if (cycles > TIMEOUT_CYCLES) begin
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        stop_run();
      end else begin
        if (user_req_valid && user_req_ready) begin
          pool.push_back(cur_idx);
        end
        if (bvalid && bready) begin
          b_seen++;
        end
        // Payload held while the slave stalls
        if (aw_stall) begin
          compare_value("aw_held_valid", 1, awvalid);
          compare_value("aw_held_payload", aw_prev, aw);
        end
        if (w_stall) begin
          compare_value("w_held_valid", 1, wvalid);
          compare_value("w_held_payload", w_prev, w);
        end
        aw_stall = awvalid && !awready;
        w_stall  = wvalid && !wready;
        aw_prev  = aw;
        w_prev   = w;
        if (awvalid && awready) begin
          hit = -1;
          foreach (pool[j]) begin
            if (reqs[pool[j]].addr == aw.addr) begin
              hit = j;
            end
          end
          if (hit < 0) begin
            $display("AW address %h belongs to no accepted, unissued request", aw.addr);
            stop_run();
          end else begin
            compare_value($sformatf("aw_fields req %0d", pool[hit]), reqs[pool[hit]], aw);
            aw_order.push_back(pool[hit]);
            pool.delete(hit);
            aw_count++;
          end
        end
        if (wvalid && wready) begin
          if (aw_order.size() == 0) begin
            $display("W beat arrived while no burst was waiting for data");
            stop_run();
          end else begin
            compare_value($sformatf("w_beat req %0d beat %0d", aw_order[0], beat_k),
                          expected_beat(reqs[aw_order[0]], bursts[aw_order[0]], beat_k), w);
            if (beat_k == int'(reqs[aw_order[0]].len)) begin
              void'(aw_order.pop_front());
              beat_k = 0;
              w_done++;
            end else begin
              beat_k++;
            end
          end
        end
      end
    end
  end

  // ------------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------------
  initial begin
    rst_n          = 1'b0;
    user_req_valid = 1'b0;
    user_req       = '0;
    user_burst     = '0;
    cur_idx        = 0;
    rnd            = '0;
    b_allow        = 0;
    beat_k         = 0;
    aw_count       = 0;
    w_done         = 0;
    b_seen         = 0;
    cycles         = 0;
    aw_stall       = 1'b0;
    w_stall        = 1'b0;
    lfsr           = 32'h787c_2260;
    build_requests();
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    compare_value("ready_after_reset", 1, user_req_ready);
    compare_value("awvalid_after_reset", 0, awvalid);
    compare_value("wvalid_after_reset", 0, wvalid);
    compare_value("bready_after_reset", 1, bready);

    // Fill every slot while B is held back
    for (int i = 0; i < NUM_SLOTS; i++) begin
      send_request(i);
    end
    compare_value("ready_when_full", 0, user_req_ready);

    // One response frees one slot
    b_allow = 1;
    while (!user_req_ready) begin
      @(negedge clk);
    end
    compare_value("b_count_at_reopen", 1, b_seen);
    send_request(NUM_SLOTS);

    b_allow = NUM_REQS;
    for (int i = NUM_SLOTS + 1; i < NUM_REQS; i++) begin
      send_request(i);
    end
    while (b_seen < NUM_REQS) begin
      @(negedge clk);
    end
    repeat (2) @(negedge clk);

    compare_value("ready_at_end", 1, user_req_ready);
    $display("Everything OK");
    $finish;
  end

endmodule

//--- dv/axi_wr_slave_model.sv
`timescale 1ns/1ps
`include "axi_wr_defs.svh"

module axi_wr_slave_model (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic [7:0]                    rnd,
  input  int                            b_allow,
  input  axi_wr_pkg::aw_req_t           aw,
  input  logic                          awvalid,
  output logic                          awready,
  input  axi_wr_pkg::w_beat_t           w,
  input  logic                          wvalid,
  output logic                          wready,
  output logic [axi_wr_pkg::ID_W-1:0]   bid,
  output logic [axi_wr_pkg::RESP_W-1:0] bresp,
  output logic                          bvalid,
  input  logic                          bready
);
  import axi_wr_pkg::*;

  logic [ID_W-1:0] aw_ids [$];
  logic [ID_W-1:0] b_pend [$];
  logic [7:0]      rnd_s;
  int              allow_s;
  int              b_sent;

  initial begin
    awready = 1'b0;
    wready  = 1'b0;
    bvalid  = 1'b0;
    bid     = '0;
    bresp   = `AXI_RESP_OKAY;
    rnd_s   = '0;
    allow_s = 0;
    b_sent  = 0;
  end

  // Bursts complete in AW order, so the W last pops the oldest ID
  always @(posedge clk) begin
    rnd_s   = rnd;
    allow_s = b_allow;
    if (!rst_n) begin
      aw_ids.delete();
      b_pend.delete();
    end else begin
      if (awvalid && awready) begin
        aw_ids.push_back(aw.id);
      end
      if (wvalid && wready && w.last) begin
        b_pend.push_back(aw_ids.pop_front());
      end
      if (bvalid && bready) begin
        b_sent++;
      end
    end
  end

  // Up to three responses wait and leave in random order
  always @(negedge clk) begin
    int span;
    int pick;
    int first;
    awready = rnd_s[0] | rnd_s[1];
    wready  = rnd_s[2] | rnd_s[3];
    if (!(bvalid && !bready)) begin
      bvalid = 1'b0;
      span   = (b_pend.size() < 3) ? b_pend.size() : 3;
      if (span > 0 && b_sent < allow_s && (span == 3 || rnd_s[4])) begin
        pick  = int'(rnd_s[6:5]) % span;
        first = pick;
        // Same ID keeps its order, take its oldest entry
        for (int j = pick - 1; j >= 0; j--) begin
          if (b_pend[j] == b_pend[pick]) begin
            first = j;
          end
        end
        bid    = b_pend[first];
        bresp  = `AXI_RESP_OKAY;
        bvalid = 1'b1;
        b_pend.delete(first);
      end
    end
  end

endmodule

//--- logic/axi_wr_master.sv
`timescale 1ns/1ps

module axi_wr_master #(
  parameter int NUM_SLOTS = 4
) (
  input  logic                          clk,
  input  logic                          rst_n,
  // User request
  input  logic                          user_req_valid,
  output logic                          user_req_ready,
  input  axi_wr_pkg::aw_req_t           user_req,
  input  axi_wr_pkg::burst_t            user_burst,
  // AW channel
  output axi_wr_pkg::aw_req_t           aw,
  output logic                          awvalid,
  input  logic                          awready,
  // W channel
  output axi_wr_pkg::w_beat_t           w,
  output logic                          wvalid,
  input  logic                          wready,
  // B channel
  input  logic [axi_wr_pkg::ID_W-1:0]   bid,
  input  logic [axi_wr_pkg::RESP_W-1:0] bresp,
  input  logic                          bvalid,
  output logic                          bready
);
  import axi_wr_pkg::*;

  localparam int IDX_W = $clog2(NUM_SLOTS);

  logic [NUM_SLOTS-1:0] pend_bits;
  logic                 aw_fire;
  logic [IDX_W-1:0]     aw_slot;
  aw_req_t              aw_rd;
  logic [IDX_W-1:0]     w_slot;
  burst_t               w_rd;
  logic [LEN_W-1:0]     w_len;
  logic                 free_en;
  logic [IDX_W-1:0]     free_slot;

  // -------------------------------------------------------------------
  // Slot storage
  // -------------------------------------------------------------------
  wr_slot_table #(
    .NUM_SLOTS(NUM_SLOTS)
  ) u_table (
    .clk           (clk),
    .rst_n         (rst_n),
    .user_req_valid(user_req_valid),
    .user_req_ready(user_req_ready),
    .user_req      (user_req),
    .user_burst    (user_burst),
    .pend_bits     (pend_bits),
    .aw_fire       (aw_fire),
    .aw_slot       (aw_slot),
    .aw_rd         (aw_rd),
    .w_slot        (w_slot),
    .w_rd          (w_rd),
    .w_len         (w_len),
    .free_en       (free_en),
    .free_slot     (free_slot)
  );

  // -------------------------------------------------------------------
  // Channel stages
  // -------------------------------------------------------------------
  aw_issue #(
    .NUM_SLOTS(NUM_SLOTS)
  ) u_aw (
    .clk      (clk),
    .rst_n    (rst_n),
    .pend_bits(pend_bits),
    .aw_rd    (aw_rd),
    .aw_slot  (aw_slot),
    .aw_fire  (aw_fire),
    .aw       (aw),
    .awvalid  (awvalid),
    .awready  (awready)
  );

  w_stream #(
    .NUM_SLOTS(NUM_SLOTS)
  ) u_w (
    .clk    (clk),
    .rst_n  (rst_n),
    .aw_fire(aw_fire),
    .aw_slot(aw_slot),
    .w_slot (w_slot),
    .w_rd   (w_rd),
    .w_len  (w_len),
    .w      (w),
    .wvalid (wvalid),
    .wready (wready)
  );

  b_tracker #(
    .NUM_SLOTS(NUM_SLOTS)
  ) u_b (
    .clk      (clk),
    .rst_n    (rst_n),
    .aw_fire  (aw_fire),
    .aw_slot  (aw_slot),
    .aw_id    (aw.id),
    .bvalid   (bvalid & bready),
    .bid      (bid),
    .free_en  (free_en),
    .free_slot(free_slot)
  );

  // Responses are always taken
  assign bready = 1'b1;

endmodule

//--- logic/b_tracker.sv
`timescale 1ns/1ps

module b_tracker #(
  parameter int NUM_SLOTS = 4
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         aw_fire,
  input  logic [$clog2(NUM_SLOTS)-1:0] aw_slot,
  input  logic [axi_wr_pkg::ID_W-1:0]  aw_id,
  input  logic                         bvalid,
  input  logic [axi_wr_pkg::ID_W-1:0]  bid,
  output logic                         free_en,
  output logic [$clog2(NUM_SLOTS)-1:0] free_slot
);
  import axi_wr_pkg::*;

  localparam int IDX_W = $clog2(NUM_SLOTS);

  typedef struct packed {
    logic [ID_W-1:0]  id;
    logic [IDX_W-1:0] slot;
  } ost_t;

  // Outstanding pairs, oldest at index 0
  ost_t                 ost_q [NUM_SLOTS];
  ost_t                 ost_d [NUM_SLOTS];
  logic [NUM_SLOTS-1:0] vld_q;
  logic [NUM_SLOTS-1:0] vld_d;
  logic                 hit;
  logic [IDX_W-1:0]     hit_idx;

  // Oldest entry with the returned ID
  always_comb begin
    hit     = 1'b0;
    hit_idx = '0;
    for (int i = NUM_SLOTS - 1; i >= 0; i--) begin
      if (vld_q[i] && ost_q[i].id == bid) begin
        hit     = bvalid;
        hit_idx = IDX_W'(i);
      end
    end
  end

  // -------------------------------------------------------------------
  // Remove the matched entry, then append the new issue at the tail
  // -------------------------------------------------------------------
  always_comb begin
    int tail;
    ost_d = ost_q;
    vld_d = vld_q;
    tail  = $countones(vld_q);
    if (hit) begin
      for (int i = 0; i < NUM_SLOTS - 1; i++) begin
        if (i >= int'(hit_idx)) begin
          ost_d[i] = ost_q[i + 1];
          vld_d[i] = vld_q[i + 1];
        end
      end
      vld_d[NUM_SLOTS-1] = 1'b0;
      tail = tail - 1;
    end
    if (aw_fire) begin
      ost_d[tail] = '{id: aw_id, slot: aw_slot};
      vld_d[tail] = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    ost_q <= ost_d;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_q     <= '0;
      free_en   <= 1'b0;
      free_slot <= '0;
    end else begin
      vld_q   <= vld_d;
      free_en <= hit;
      if (hit) begin
        free_slot <= ost_q[hit_idx].slot;
      end
    end
  end

  // Every response belongs to an issued, unanswered write
  a_bid_known: assert property (@(posedge clk) disable iff (!rst_n)
    bvalid |-> hit);

endmodule

//--- logic/w_stream.sv
`timescale 1ns/1ps

module w_stream #(
  parameter int NUM_SLOTS = 4
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         aw_fire,
  input  logic [$clog2(NUM_SLOTS)-1:0] aw_slot,
  output logic [$clog2(NUM_SLOTS)-1:0] w_slot,
  input  axi_wr_pkg::burst_t           w_rd,
  input  logic [axi_wr_pkg::LEN_W-1:0] w_len,
  output axi_wr_pkg::w_beat_t          w,
  output logic                         wvalid,
  input  logic                         wready
);
  import axi_wr_pkg::*;

  localparam int IDX_W  = $clog2(NUM_SLOTS);
  localparam int CNT_W  = $clog2(NUM_SLOTS + 1);
  localparam int BEAT_W = $clog2(MAX_BURST_LEN);

  logic [IDX_W-1:0] order_q [NUM_SLOTS];
  logic [IDX_W-1:0] wr_ptr;
  logic [IDX_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic [LEN_W-1:0] beat_cnt;
  logic             head_last;
  logic             load;
  logic             pop;

  function automatic logic [IDX_W-1:0] next_idx(input logic [IDX_W-1:0] idx);
    return (int'(idx) == NUM_SLOTS - 1) ? '0 : idx + 1'b1;
  endfunction

  // -------------------------------------------------------------------
  // Slot order FIFO, filled in AW handshake order
  // -------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (aw_fire) begin
      order_q[wr_ptr] <= aw_slot;
    end
  end

  assign w_slot    = order_q[rd_ptr];
  assign load      = (count != '0) && (!wvalid || wready);
  assign head_last = (beat_cnt == w_len);
  assign pop       = load && head_last;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      beat_cnt <= '0;
      wvalid   <= 1'b0;
    end else begin
      if (aw_fire) begin
        wr_ptr <= next_idx(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_idx(rd_ptr);
      end
      count <= count + CNT_W'(aw_fire) - CNT_W'(pop);
      if (load) begin
        beat_cnt <= head_last ? '0 : beat_cnt + 1'b1;
      end
      // W holding register refills in the handshake cycle
      if (load) begin
        wvalid <= 1'b1;
      end else if (wready) begin
        wvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      w.data <= w_rd.words[beat_cnt[BEAT_W-1:0]];
      w.strb <= w_rd.strbs[beat_cnt[BEAT_W-1:0]];
      w.last <= head_last;
    end
  end

  // Beat index never runs past the head burst, so last always comes
  a_beat_in_burst: assert property (@(posedge clk) disable iff (!rst_n)
    load |-> beat_cnt <= w_len);

  // One FIFO entry per slot is enough
  a_order_room: assert property (@(posedge clk) disable iff (!rst_n)
    aw_fire |-> count < CNT_W'(NUM_SLOTS));

endmodule

//--- logic/aw_issue.sv
`timescale 1ns/1ps

module aw_issue #(
  parameter int NUM_SLOTS = 4
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic [NUM_SLOTS-1:0]         pend_bits,
  input  axi_wr_pkg::aw_req_t          aw_rd,
  output logic [$clog2(NUM_SLOTS)-1:0] aw_slot,
  output logic                         aw_fire,
  output axi_wr_pkg::aw_req_t          aw,
  output logic                         awvalid,
  input  logic                         awready
);
  import axi_wr_pkg::*;

  localparam int IDX_W = $clog2(NUM_SLOTS);

  logic [NUM_SLOTS-1:0] held_mask;
  logic [NUM_SLOTS-1:0] cand_bits;
  logic [IDX_W-1:0]     pick;
  logic                 pick_any;
  logic                 load;

  // Slot in the holding register stays pending until its handshake
  assign held_mask = awvalid ? NUM_SLOTS'(1) << aw_slot : '0;
  assign cand_bits = pend_bits & ~held_mask;

  rr_slot_picker #(
    .NUM_SLOTS(NUM_SLOTS)
  ) u_pend_pick (
    .clk     (clk),
    .rst_n   (rst_n),
    .req_bits(cand_bits),
    .take    (load),
    .grant   (pick),
    .any     (pick_any)
  );

  assign aw_fire = awvalid & awready;
  assign load    = pick_any & (~awvalid | awready);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      awvalid <= 1'b0;
      aw_slot <= '0;
    end else if (load) begin
      awvalid <= 1'b1;
      aw_slot <= pick;
    end else if (aw_fire) begin
      awvalid <= 1'b0;
    end
  end

  assign aw = awvalid ? aw_rd : AW_REQ_IDLE;

  // Address payload must hold under back-pressure
  a_aw_stable: assert property (@(posedge clk) disable iff (!rst_n)
    awvalid && !awready |=> awvalid && $stable(aw));

endmodule

//--- logic/wr_slot_table.sv
`timescale 1ns/1ps

module wr_slot_table #(
  parameter int NUM_SLOTS = 4
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         user_req_valid,
  output logic                         user_req_ready,
  input  axi_wr_pkg::aw_req_t          user_req,
  input  axi_wr_pkg::burst_t           user_burst,
  output logic [NUM_SLOTS-1:0]         pend_bits,
  input  logic                         aw_fire,
  input  logic [$clog2(NUM_SLOTS)-1:0] aw_slot,
  output axi_wr_pkg::aw_req_t          aw_rd,
  input  logic [$clog2(NUM_SLOTS)-1:0] w_slot,
  output axi_wr_pkg::burst_t           w_rd,
  output logic [axi_wr_pkg::LEN_W-1:0] w_len,
  input  logic                         free_en,
  input  logic [$clog2(NUM_SLOTS)-1:0] free_slot
);
  import axi_wr_pkg::*;

  localparam int IDX_W = $clog2(NUM_SLOTS);

  logic [NUM_SLOTS-1:0] valid_bits;
  logic [IDX_W-1:0]     new_slot;
  logic                 accept;
  logic [NUM_SLOTS-1:0] set_mask;
  logic [NUM_SLOTS-1:0] fire_mask;
  logic [NUM_SLOTS-1:0] free_mask;
  aw_req_t              req_mem [NUM_SLOTS];
  burst_t               burst_mem [NUM_SLOTS];

  // Free slot choice, ready while any slot is empty
  rr_slot_picker #(
    .NUM_SLOTS(NUM_SLOTS)
  ) u_free_pick (
    .clk     (clk),
    .rst_n   (rst_n),
    .req_bits(~valid_bits),
    .take    (accept),
    .grant   (new_slot),
    .any     (user_req_ready)
  );

  assign accept    = user_req_valid & user_req_ready;
  assign set_mask  = accept ? NUM_SLOTS'(1) << new_slot : '0;
  assign fire_mask = aw_fire ? NUM_SLOTS'(1) << aw_slot : '0;
  assign free_mask = free_en ? NUM_SLOTS'(1) << free_slot : '0;

  // -------------------------------------------------------------------
  // Slot status
  // -------------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_bits <= '0;
      pend_bits  <= '0;
    end else begin
      valid_bits <= (valid_bits & ~free_mask) | set_mask;
      pend_bits  <= (pend_bits & ~fire_mask) | set_mask;
    end
  end

  // Payload written once per accept
  always_ff @(posedge clk) begin
    if (accept) begin
      req_mem[new_slot]   <= user_req;
      burst_mem[new_slot] <= user_burst;
    end
  end

  // Read ports for the AW and W stages
  assign aw_rd = req_mem[aw_slot];
  assign w_rd  = burst_mem[w_slot];
  assign w_len = req_mem[w_slot].len;

  // No accept into an occupied slot, so never while full
  a_accept_empty: assert property (@(posedge clk) disable iff (!rst_n)
    accept |-> !valid_bits[new_slot]);

  // A slot is released only after its address phase went out
  a_free_issued: assert property (@(posedge clk) disable iff (!rst_n)
    free_en |-> valid_bits[free_slot] && !pend_bits[free_slot]);

endmodule

//--- logic/rr_slot_picker.sv
`timescale 1ns/1ps

module rr_slot_picker #(
  parameter int NUM_SLOTS = 4
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic [NUM_SLOTS-1:0]         req_bits,
  input  logic                         take,
  output logic [$clog2(NUM_SLOTS)-1:0] grant,
  output logic                         any
);
  localparam int IDX_W = $clog2(NUM_SLOTS);

  logic [IDX_W-1:0] ptr;

  // Scan downward from the farthest offset
  // so the requester nearest the pointer is the last one written
  always_comb begin
    int idx;
    grant = '0;
    any   = 1'b0;
    for (int i = NUM_SLOTS - 1; i >= 0; i--) begin
      idx = (int'(ptr) + i) % NUM_SLOTS;
      if (req_bits[idx]) begin
        grant = IDX_W'(idx);
        any   = 1'b1;
      end
    end
  end

  // Priority moves just past the slot that was taken
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ptr <= '0;
    end else if (take) begin
      ptr <= (int'(grant) == NUM_SLOTS - 1) ? '0 : grant + 1'b1;
    end
  end

endmodule

//--- logic/axi_wr_pkg.sv
`include "axi_wr_defs.svh"

package axi_wr_pkg;

  // Field widths
  localparam int ID_W    = 4;
  localparam int ADDR_W  = 32;
  localparam int DATA_W  = 32;
  localparam int STRB_W  = DATA_W / 8;
  localparam int LEN_W   = 8;
  localparam int SIZE_W  = 3;
  localparam int BURST_W = 2;
  localparam int RESP_W  = 2;

  // Data words held per slot
  localparam int MAX_BURST_LEN = 4;

  typedef struct packed {
    logic [ID_W-1:0]    id;
    logic [ADDR_W-1:0]  addr;
    logic [LEN_W-1:0]   len;
    logic [SIZE_W-1:0]  size;
    logic [BURST_W-1:0] burst;
  } aw_req_t;

  typedef struct packed {
    logic [MAX_BURST_LEN-1:0][DATA_W-1:0] words;
    logic [MAX_BURST_LEN-1:0][STRB_W-1:0] strbs;
  } burst_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
    logic              last;
  } w_beat_t;

  // Idle value of the AW bus, full-width INCR
  localparam aw_req_t AW_REQ_IDLE = '{
    id:    '0,
    addr:  '0,
    len:   '0,
    size:  SIZE_W'($clog2(STRB_W)),
    burst: `AXI_BURST_INCR
  };

  localparam logic [RESP_W-1:0] RESP_OKAY = `AXI_RESP_OKAY;

endpackage

//--- include/axi_wr_defs.svh
`ifndef AXI_WR_DEFS_SVH
`define AXI_WR_DEFS_SVH

// AXI burst types
`define AXI_BURST_FIXED 2'b00
`define AXI_BURST_INCR  2'b01
`define AXI_BURST_WRAP  2'b10

// AXI write response codes
`define AXI_RESP_OKAY   2'b00
`define AXI_RESP_EXOKAY 2'b01
`define AXI_RESP_SLVERR 2'b10
`define AXI_RESP_DECERR 2'b11

`endif
